// ==== verilog/sp3_rx_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared constants and types of the dual lane receiver core
// Frame bit 255 is sent first; three parity bits stand in for the FEC
//////////////////////////////////////////////////////////////////////

package sp3_rx_pkg;

   ///////////////////////////////////////////////////////////////////
   // Frame geometry
   localparam int unsigned WORD_W      = 32;              // Transceiver word
   localparam int unsigned FRAME_WORDS = 8;               // Words per lane frame
   localparam int unsigned FRAME_W     = WORD_W * FRAME_WORDS;
   localparam int unsigned USER_W      = 230;

   // Field positions inside the frame
   localparam int unsigned IC_LSB   = 252;
   localparam int unsigned EC_LSB   = 250;
   localparam int unsigned USER_LSB = 20;
   localparam int unsigned PAR_USER = 19;                 // Even parity over user
   localparam int unsigned PAR_EC   = 18;
   localparam int unsigned PAR_IC   = 17;

   ///////////////////////////////////////////////////////////////////
   // Alignment
   localparam int unsigned SLIP_WAIT_FRAMES = 2;          // Frames ignored after a slip
   localparam int unsigned REQ_TRUE_HEADERS = 8;          // Good headers to lock
   localparam int unsigned FALSE_WINDOW     = 32;         // Frames per false header window
   localparam int unsigned ALLOWED_FALSE    = 4;          // One more unlocks
   localparam int unsigned CNT_W            = $clog2(FALSE_WINDOW);
   localparam int unsigned FALSE_W          = $clog2(ALLOWED_FALSE + 1);

   ///////////////////////////////////////////////////////////////////
   // Types
   typedef logic [WORD_W-1:0]              word_t;
   typedef logic [FRAME_W-1:0]             frame_bits_t;
   typedef logic [USER_W-1:0]              user_t;
   typedef logic [1:0]                     ec_t;
   typedef logic [1:0]                     ic_t;
   typedef logic [$clog2(WORD_W)-1:0]      offset_t;    // Bit offset in lane stream
   typedef logic [$clog2(FRAME_WORDS)-1:0] wpos_t;      // Word slot in frame
   typedef logic [15:0]                    errcnt_t;
   typedef logic [1:0]                     reg_addr_t;
   typedef logic [15:0]                    reg_data_t;

   // Register map
   localparam reg_addr_t ADDR_CTRL     = 2'd0;
   localparam reg_addr_t ADDR_STATUS   = 2'd1;
   localparam reg_addr_t ADDR_ERRCNT_A = 2'd2;
   localparam reg_addr_t ADDR_ERRCNT_B = 2'd3;

   typedef enum logic [1:0] {HUNT, SLIP_WAIT, VERIFY, LOCKED} align_state_t;

   // Decoded lane frame, 236 bits
   typedef struct packed {
      logic  valid;      // One cycle per frame
      user_t user;
      ec_t   ec;
      ic_t   ic;
      logic  fec_err;    // Parity failure, detected only
   } rx_frame_t;

endpackage

// ==== verilog/sp3_demux.sv ====
//////////////////////////////////////////////////////////////////////
// Splits interleaved words into lanes A and B, A takes the first word
// Lane word is a window of the previous lane word, one word behind input
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sp3_demux (
   input  logic              MGT_RXCLK,
   input  logic              rst_n_i,
   input  sp3_rx_pkg::word_t mgt_word_i,
   input  logic              polarity_i,
   input  logic              bitslip_a_i,
   input  logic              bitslip_b_i,
   input  logic              lane_rst_a_i,
   input  logic              lane_rst_b_i,
   output sp3_rx_pkg::word_t word_a_o,
   output logic              strobe_a_o,
   output sp3_rx_pkg::word_t word_b_o,
   output logic              strobe_b_o
);

   logic              sel_q;          // 0 = word belongs to lane A
   sp3_rx_pkg::word_t word_pol;       // Input after polarity
   logic              slip [2];
   logic              lrst [2];
   sp3_rx_pkg::word_t lane_word [2];
   logic              lane_stb [2];

   assign word_pol = polarity_i ? ~mgt_word_i : mgt_word_i;

   assign slip[0]    = bitslip_a_i;
   assign slip[1]    = bitslip_b_i;
   assign lrst[0]    = lane_rst_a_i;
   assign lrst[1]    = lane_rst_b_i;
   assign word_a_o   = lane_word[0];
   assign strobe_a_o = lane_stb[0];
   assign word_b_o   = lane_word[1];
   assign strobe_b_o = lane_stb[1];

   // Lane selector, toggles every cycle
   always_ff @(posedge MGT_RXCLK) begin
      if (!rst_n_i) sel_q <= 1'b0;
      else          sel_q <= ~sel_q;
   end

   for (genvar l = 0; l < 2; l++) begin : g_lane
      sp3_rx_pkg::word_t               last_q;   // Previous word of this lane
      sp3_rx_pkg::offset_t             off_q;    // Bitslip count mod 32
      logic                            skip_q;   // Drop next strobe after wrap
      logic                            take;
      logic [2*sp3_rx_pkg::WORD_W-1:0] win;

      assign take = (sel_q == 1'(l));
      assign win  = {last_q, word_pol} << off_q;   // Offset n starts n bits later

      // Lane history and shifted word
      always_ff @(posedge MGT_RXCLK) begin
         if (take) begin
            last_q       <= word_pol;
            lane_word[l] <= win[2*sp3_rx_pkg::WORD_W-1 -: sp3_rx_pkg::WORD_W];
         end
      end

      always_ff @(posedge MGT_RXCLK) begin
         if (!rst_n_i || lrst[l]) begin
            off_q       <= '0;
            skip_q      <= 1'b0;
            lane_stb[l] <= 1'b0;
         end else begin
            lane_stb[l] <= take & ~skip_q;
            if (take) skip_q <= 1'b0;
            if (slip[l]) begin
               off_q <= off_q + 1'b1;
               // 31 -> 0 is a whole word back, so one strobe is dropped
               if (off_q == '1) skip_q <= 1'b1;
            end
         end
      end
   end

endmodule

// ==== verilog/sp3_frame_aligner.sv ====
//////////////////////////////////////////////////////////////////////
// Per-lane header search, one bitslip per bad header while hunting
// Header sits in the top two bits of word 0, valid values 01 and 10
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sp3_frame_aligner (
   input  logic              MGT_RXCLK,
   input  logic              rst_n_i,
   input  logic              lane_rst_i,
   input  sp3_rx_pkg::word_t word_i,
   input  logic              strobe_i,
   output logic              bitslip_o,
   output sp3_rx_pkg::wpos_t wpos_o,
   output logic              lock_o
);

   sp3_rx_pkg::align_state_t       state_q;
   sp3_rx_pkg::wpos_t              wpos_q;     // Slot of the word on word_i
   logic [sp3_rx_pkg::CNT_W-1:0]   cnt_q;      // Wait, verify or window count
   logic [sp3_rx_pkg::FALSE_W-1:0] false_q;    // Bad headers in window
   logic                           hdr_chk;    // Word 0 present
   logic                           hdr_ok;

   assign hdr_chk = strobe_i && (wpos_q == '0);
   assign hdr_ok  = word_i[sp3_rx_pkg::WORD_W-1] ^ word_i[sp3_rx_pkg::WORD_W-2];
   assign wpos_o  = wpos_q;
   assign lock_o  = (state_q == sp3_rx_pkg::LOCKED);

   always_ff @(posedge MGT_RXCLK) begin
      if (!rst_n_i || lane_rst_i) begin
         state_q   <= sp3_rx_pkg::HUNT;
         wpos_q    <= '0;
         cnt_q     <= '0;
         false_q   <= '0;
         bitslip_o <= 1'b0;
      end else begin
         bitslip_o <= 1'b0;                        // Single cycle pulse
         if (strobe_i) wpos_q <= wpos_q + 1'b1;    // Wraps at 8

         if (hdr_chk) begin
            case (state_q)
               sp3_rx_pkg::HUNT: begin
                  if (hdr_ok) begin
                     state_q <= sp3_rx_pkg::VERIFY;
                     cnt_q   <= 1;                  // This header counts
                  end else begin
                     bitslip_o <= 1'b1;
                     state_q   <= sp3_rx_pkg::SLIP_WAIT;
                     cnt_q     <= '0;
                  end
               end

               // Let the slip settle before testing again
               sp3_rx_pkg::SLIP_WAIT: begin
                  if (cnt_q == sp3_rx_pkg::SLIP_WAIT_FRAMES - 1) state_q <= sp3_rx_pkg::HUNT;
                  else cnt_q <= cnt_q + 1'b1;
               end

               sp3_rx_pkg::VERIFY: begin
                  if (!hdr_ok) begin
                     state_q <= sp3_rx_pkg::HUNT;   // Any miss restarts
                  end else if (cnt_q == sp3_rx_pkg::REQ_TRUE_HEADERS - 1) begin
                     state_q <= sp3_rx_pkg::LOCKED;
                     cnt_q   <= '0;
                     false_q <= '0;
                  end else begin
                     cnt_q <= cnt_q + 1'b1;
                  end
               end

               // Tolerate a few bad headers per window
               sp3_rx_pkg::LOCKED: begin
                  if (!hdr_ok && (false_q == sp3_rx_pkg::ALLOWED_FALSE)) begin
                     state_q <= sp3_rx_pkg::HUNT;
                  end else if (cnt_q == sp3_rx_pkg::FALSE_WINDOW - 1) begin
                     cnt_q   <= '0;                 // New window
                     false_q <= '0;
                  end else begin
                     cnt_q   <= cnt_q + 1'b1;
                     false_q <= false_q + {{(sp3_rx_pkg::FALSE_W-1){1'b0}}, !hdr_ok};
                  end
               end

               default: state_q <= sp3_rx_pkg::HUNT;
            endcase
         end
      end
   end

endmodule

// ==== verilog/sp3_frame_decoder.sv ====
//////////////////////////////////////////////////////////////////////
// Per-lane frame assembly and field split, publishes only while locked
// Parity check detects errors, nothing is corrected
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sp3_frame_decoder (
   input  logic                  MGT_RXCLK,
   input  logic                  rst_n_i,
   input  logic                  lane_rst_i,
   input  sp3_rx_pkg::word_t     word_i,
   input  logic                  strobe_i,
   input  sp3_rx_pkg::wpos_t     wpos_i,
   input  logic                  lock_i,
   output sp3_rx_pkg::rx_frame_t frame_o
);

   sp3_rx_pkg::word_t       slot_q [sp3_rx_pkg::FRAME_WORDS-1];  // Words 0..6
   sp3_rx_pkg::frame_bits_t fr;          // Stored words plus word 7 on input
   logic                    last_stb;    // Strobe with word 7
   logic                    publish;
   logic                    par_err;
   logic                    valid_q;
   logic                    fec_q;
   sp3_rx_pkg::user_t       user_q;
   sp3_rx_pkg::ec_t         ec_q;
   sp3_rx_pkg::ic_t         ic_q;

   assign last_stb = strobe_i && (wpos_i == '1);
   assign publish  = last_stb && lock_i;

   // Word k lands at bits 255-32k downto 224-32k
   always_comb begin
      for (int k = 0; k < sp3_rx_pkg::FRAME_WORDS - 1; k++) begin
         fr[sp3_rx_pkg::FRAME_W-1-sp3_rx_pkg::WORD_W*k -: sp3_rx_pkg::WORD_W] = slot_q[k];
      end
      fr[sp3_rx_pkg::WORD_W-1:0] = word_i;
   end

   // Each group plus its parity bit must be even
   assign par_err =
      (^{fr[sp3_rx_pkg::USER_LSB +: sp3_rx_pkg::USER_W], fr[sp3_rx_pkg::PAR_USER]}) |
      (^{fr[sp3_rx_pkg::EC_LSB +: $bits(sp3_rx_pkg::ec_t)], fr[sp3_rx_pkg::PAR_EC]}) |
      (^{fr[sp3_rx_pkg::IC_LSB +: $bits(sp3_rx_pkg::ic_t)], fr[sp3_rx_pkg::PAR_IC]});

   // Slot fill, word 7 is used straight from the input
   always_ff @(posedge MGT_RXCLK) begin
      if (strobe_i && !last_stb) slot_q[wpos_i] <= word_i;
   end

   // Payload fields hold until the next frame
   always_ff @(posedge MGT_RXCLK) begin
      if (publish) begin
         user_q <= fr[sp3_rx_pkg::USER_LSB +: sp3_rx_pkg::USER_W];
         ec_q   <= fr[sp3_rx_pkg::EC_LSB +: $bits(sp3_rx_pkg::ec_t)];
         ic_q   <= fr[sp3_rx_pkg::IC_LSB +: $bits(sp3_rx_pkg::ic_t)];
      end
   end

   always_ff @(posedge MGT_RXCLK) begin
      if (!rst_n_i || lane_rst_i) begin
         valid_q <= 1'b0;
         fec_q   <= 1'b0;
      end else begin
         valid_q <= publish;                 // Cycle after word 7 strobe
         if (publish) fec_q <= par_err;
      end
   end

   assign frame_o = '{valid: valid_q, user: user_q, ec: ec_q, ic: ic_q, fec_err: fec_q};

endmodule

// ==== verilog/sp3_rx_regs.sv ====
//////////////////////////////////////////////////////////////////////
// CTRL, STATUS and two error counters, read data one cycle after addr
// Error counters saturate, any write to their address clears them
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sp3_rx_regs (
   input  logic                  MGT_RXCLK,
   input  logic                  rst_n_i,
   input  logic                  cfg_we_i,
   input  sp3_rx_pkg::reg_addr_t cfg_addr_i,
   input  sp3_rx_pkg::reg_data_t cfg_wdata_i,
   output sp3_rx_pkg::reg_data_t cfg_rdata_o,
   input  logic                  lock_a_i,
   input  logic                  lock_b_i,
   input  logic                  frame_err_a_i,
   input  logic                  frame_err_b_i,
   output logic                  polarity_o,
   output logic                  lane_rst_a_o,
   output logic                  lane_rst_b_o
);

   sp3_rx_pkg::errcnt_t   cnt_q [2];
   logic                  err [2];
   sp3_rx_pkg::reg_data_t rdata_q;

   assign err[0]      = frame_err_a_i;
   assign err[1]      = frame_err_b_i;
   assign cfg_rdata_o = rdata_q;

   // CTRL bits: 0 polarity, 1 lane A reset, 2 lane B reset
   always_ff @(posedge MGT_RXCLK) begin
      if (!rst_n_i) begin
         polarity_o   <= 1'b0;
         lane_rst_a_o <= 1'b0;
         lane_rst_b_o <= 1'b0;
      end else if (cfg_we_i && (cfg_addr_i == sp3_rx_pkg::ADDR_CTRL)) begin
         polarity_o   <= cfg_wdata_i[0];
         lane_rst_a_o <= cfg_wdata_i[1];
         lane_rst_b_o <= cfg_wdata_i[2];
      end
   end

   for (genvar l = 0; l < 2; l++) begin : g_errcnt
      always_ff @(posedge MGT_RXCLK) begin
         if (!rst_n_i) begin
            cnt_q[l] <= '0;
         end else if (cfg_we_i &&
                      (cfg_addr_i == ((l == 0) ? sp3_rx_pkg::ADDR_ERRCNT_A
                                               : sp3_rx_pkg::ADDR_ERRCNT_B))) begin
            cnt_q[l] <= '0;                        // Clear wins over a new error
         end else if (err[l] && (cnt_q[l] != '1)) begin
            cnt_q[l] <= cnt_q[l] + 1'b1;
         end
      end
   end

   // Registered read mux
   always_ff @(posedge MGT_RXCLK) begin
      if (!rst_n_i) begin
         rdata_q <= '0;
      end else begin
         case (cfg_addr_i)
            sp3_rx_pkg::ADDR_CTRL:     rdata_q <= {13'd0, lane_rst_b_o, lane_rst_a_o, polarity_o};
            sp3_rx_pkg::ADDR_STATUS:   rdata_q <= {14'd0, lock_b_i, lock_a_i};
            sp3_rx_pkg::ADDR_ERRCNT_A: rdata_q <= cnt_q[0];
            default:                   rdata_q <= cnt_q[1];
         endcase
      end
   end

endmodule

// ==== verilog/sp3_dual_rx.sv ====
//////////////////////////////////////////////////////////////////////
// Dual lane receiver core on MGT_RXCLK, one transceiver word per cycle
// Frames come out at full rate with no back-pressure
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sp3_dual_rx (
   input  logic                  MGT_RXCLK,
   input  logic                  rst_n_i,
   input  sp3_rx_pkg::word_t     mgt_word_i,
   input  logic                  cfg_we_i,
   input  sp3_rx_pkg::reg_addr_t cfg_addr_i,
   input  sp3_rx_pkg::reg_data_t cfg_wdata_i,
   output sp3_rx_pkg::reg_data_t cfg_rdata_o,
   output sp3_rx_pkg::rx_frame_t frame_a_o,
   output sp3_rx_pkg::rx_frame_t frame_b_o,
   output logic                  rdy_a_o,
   output logic                  rdy_b_o
);

   sp3_rx_pkg::word_t word_a, word_b;      // Lane words after shift
   logic              stb_a, stb_b;
   logic              slip_a, slip_b;      // Aligner back to demux
   sp3_rx_pkg::wpos_t wpos_a, wpos_b;
   logic              lock_a, lock_b;
   logic              polarity;
   logic              lane_rst_a, lane_rst_b;

   ///////////////////////////////////////////////////////////////////
   // Lane split
   sp3_demux i_demux (
      .MGT_RXCLK    (MGT_RXCLK),
      .rst_n_i      (rst_n_i),
      .mgt_word_i   (mgt_word_i),
      .polarity_i   (polarity),
      .bitslip_a_i  (slip_a),
      .bitslip_b_i  (slip_b),
      .lane_rst_a_i (lane_rst_a),
      .lane_rst_b_i (lane_rst_b),
      .word_a_o     (word_a),
      .strobe_a_o   (stb_a),
      .word_b_o     (word_b),
      .strobe_b_o   (stb_b)
   );

   ///////////////////////////////////////////////////////////////////
   // Lane A and B alignment and decode
   sp3_frame_aligner i_align_a (
      .MGT_RXCLK (MGT_RXCLK), .rst_n_i (rst_n_i), .lane_rst_i (lane_rst_a),
      .word_i    (word_a),    .strobe_i (stb_a),  .bitslip_o  (slip_a),
      .wpos_o    (wpos_a),    .lock_o   (lock_a)
   );

   sp3_frame_aligner i_align_b (
      .MGT_RXCLK (MGT_RXCLK), .rst_n_i (rst_n_i), .lane_rst_i (lane_rst_b),
      .word_i    (word_b),    .strobe_i (stb_b),  .bitslip_o  (slip_b),
      .wpos_o    (wpos_b),    .lock_o   (lock_b)
   );

   sp3_frame_decoder i_dec_a (
      .MGT_RXCLK (MGT_RXCLK), .rst_n_i (rst_n_i), .lane_rst_i (lane_rst_a),
      .word_i    (word_a),    .strobe_i (stb_a),  .wpos_i     (wpos_a),
      .lock_i    (lock_a),    .frame_o  (frame_a_o)
   );

   sp3_frame_decoder i_dec_b (
      .MGT_RXCLK (MGT_RXCLK), .rst_n_i (rst_n_i), .lane_rst_i (lane_rst_b),
      .word_i    (word_b),    .strobe_i (stb_b),  .wpos_i     (wpos_b),
      .lock_i    (lock_b),    .frame_o  (frame_b_o)
   );

   ///////////////////////////////////////////////////////////////////
   // Config and status
   sp3_rx_regs i_regs (
      .MGT_RXCLK     (MGT_RXCLK),
      .rst_n_i       (rst_n_i),
      .cfg_we_i      (cfg_we_i),
      .cfg_addr_i    (cfg_addr_i),
      .cfg_wdata_i   (cfg_wdata_i),
      .cfg_rdata_o   (cfg_rdata_o),
      .lock_a_i      (lock_a),
      .lock_b_i      (lock_b),
      .frame_err_a_i (frame_a_o.valid & frame_a_o.fec_err),   // Count once per frame
      .frame_err_b_i (frame_b_o.valid & frame_b_o.fec_err),
      .polarity_o    (polarity),
      .lane_rst_a_o  (lane_rst_a),
      .lane_rst_b_o  (lane_rst_b)
   );

   assign rdy_a_o = lock_a;
   assign rdy_b_o = lock_b;

endmodule

// ==== test/sp3_dual_rx_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the dual lane receiver with a serial link model
// Filler frames carry zero data and headers 01 01 10 10 in turn
// Table frames are sent only while both lanes are locked
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sp3_dual_rx_tb;

   ///////////////////////////////////////////////////////////////////
   // Run length
   localparam int HUNT_CYCLES    = 256 * 3 * 16;   // Every bit position, 3 frames per slip
   localparam int TAB_ROWS       = 8;
   localparam int RAW_CYCLES     = HUNT_CYCLES + (8 + TAB_ROWS) * 16 * 2;
   localparam int PHASE_CYCLES   = ((RAW_CYCLES + 19999) / 20000) * 20000;
   localparam int LOCK_PHASES    = 3;              // Start, polarity relock, lane B relock
   localparam int TIMEOUT_CYCLES = LOCK_PHASES * PHASE_CYCLES;
   localparam logic [TAB_ROWS-1:0] CORRUPT_ROWS = 8'b1010_0100;   // Rows 2, 5 and 7

   typedef struct packed {
      logic              lane;       // 0 = lane A
      sp3_rx_pkg::ic_t   ic;
      sp3_rx_pkg::ec_t   ec;
      sp3_rx_pkg::user_t user;       // Data the parity covers
      logic              corrupt;
      sp3_rx_pkg::user_t exp_user;   // Data on the wire, one bit flipped if corrupt
   } row_t;

   logic                  MGT_RXCLK;
   logic                  rst_n_i;
   sp3_rx_pkg::word_t     mgt_word_i;
   logic                  cfg_we_i;
   sp3_rx_pkg::reg_addr_t cfg_addr_i;
   sp3_rx_pkg::reg_data_t cfg_wdata_i;
   sp3_rx_pkg::reg_data_t cfg_rdata_o;
   sp3_rx_pkg::rx_frame_t frame_a_o, frame_b_o;
   logic                  rdy_a_o, rdy_b_o;

   row_t tab [TAB_ROWS];
   bit   q_a [$];                    // Lane A bits, next one sent at the front
   bit   q_b [$];
   int   exp_a [$];                  // Table rows still due per lane
   int   exp_b [$];
   int   fill_cnt [2];
   int   seed;
   int   cycle_cnt;
   bit   lane_nxt;                   // Lane of the next link word
   bit   invert;                     // Link inverts every bit
   bit   check_on;

   sp3_dual_rx i_sp3_dual_rx (
      .MGT_RXCLK   (MGT_RXCLK),   .rst_n_i     (rst_n_i),     .mgt_word_i (mgt_word_i),
      .cfg_we_i    (cfg_we_i),    .cfg_addr_i  (cfg_addr_i),  .cfg_wdata_i (cfg_wdata_i),
      .cfg_rdata_o (cfg_rdata_o), .frame_a_o   (frame_a_o),   .frame_b_o  (frame_b_o),
      .rdy_a_o     (rdy_a_o),     .rdy_b_o     (rdy_b_o)
   );

   initial begin
      MGT_RXCLK = 1'b0;
      forever #50 MGT_RXCLK = ~MGT_RXCLK;
   end

   ///////////////////////////////////////////////////////////////////
   // Error reporting
   task automatic halt_failed();
      $display("TB FAILED");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic report_value(input string name, input logic [255:0] exp,
                               input logic [255:0] act);
      $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
      halt_failed();
   endtask

   task automatic report_error(input string what);
      $display("ERROR: %s", what);
      halt_failed();
   endtask

   ///////////////////////////////////////////////////////////////////
   // Link model
   // Header, IC, EC, user, then even parity for user, EC and IC
   function automatic sp3_rx_pkg::frame_bits_t make_frame(input logic [1:0] hdr,
         input sp3_rx_pkg::ic_t ic, input sp3_rx_pkg::ec_t ec, input sp3_rx_pkg::user_t user);
      sp3_rx_pkg::frame_bits_t f;
      f          = '0;
      f[255:254] = hdr;
      f[253:252] = ic;
      f[251:250] = ec;
      f[249:20]  = user;
      f[19]      = ^user;
      f[18]      = ^ec;
      f[17]      = ^ic;
      return f;
   endfunction

   task automatic push_frame(input int lane, input sp3_rx_pkg::frame_bits_t f, input int skip);
      for (int i = 255 - skip; i >= 0; i--) begin   // Bit 255 goes first
         if (lane == 0) q_a.push_back(f[i]);
         else           q_b.push_back(f[i]);
      end
   endtask

   task automatic push_filler(input int lane, input int skip);
      logic [1:0] hdr;
      hdr            = fill_cnt[lane][1] ? 2'b10 : 2'b01;   // Wrong offsets fail twice in a row
      fill_cnt[lane] = fill_cnt[lane] + 1;
      push_frame(lane, make_frame(hdr, '0, '0, '0), skip);
   endtask

   task automatic pop_word(input int lane, output sp3_rx_pkg::word_t w);
      if (lane == 0 && q_a.size() < 32) push_filler(0, 0);
      if (lane == 1 && q_b.size() < 32) push_filler(1, 0);
      for (int i = 31; i >= 0; i--) begin              // MSB is sent first
         if (lane == 0) w[i] = q_a.pop_front();
         else           w[i] = q_b.pop_front();
      end
   endtask

   // One word per cycle, lane A only while in reset, then B, A, B
   always @(posedge MGT_RXCLK) begin : link_drive
      sp3_rx_pkg::word_t w;
      bit                cur;
      cur = rst_n_i ? lane_nxt : 1'b0;
      pop_word(cur, w);
      lane_nxt = ~cur;
      mgt_word_i <= invert ? ~w : w;
   end

   always @(posedge MGT_RXCLK) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > TIMEOUT_CYCLES)
         report_error($sformatf("timeout after %0d cycles, no lock or frames missing",
                                TIMEOUT_CYCLES));
   end

   ///////////////////////////////////////////////////////////////////
   // Register access and table
   task automatic write_reg(input sp3_rx_pkg::reg_addr_t a, input sp3_rx_pkg::reg_data_t d);
      @(posedge MGT_RXCLK);
      cfg_we_i    <= 1'b1;
      cfg_addr_i  <= a;
      cfg_wdata_i <= d;
      @(posedge MGT_RXCLK);
      cfg_we_i    <= 1'b0;
   endtask

   task automatic check_reg(input string name, input sp3_rx_pkg::reg_addr_t a,
                            input sp3_rx_pkg::reg_data_t exp);
      @(posedge MGT_RXCLK);
      cfg_addr_i <= a;
      @(posedge MGT_RXCLK);                             // Read data registered here
      @(negedge MGT_RXCLK);
      assert (cfg_rdata_o == exp) else report_value(name, exp, cfg_rdata_o);
   endtask

   task automatic build_table();
      logic [255:0]      rnd;
      int                tmp;
      int                flip;
      sp3_rx_pkg::user_t u;
      rnd = '0;
      for (int r = 0; r < TAB_ROWS; r++) begin
         for (int w = 0; w < 8; w++) rnd = {rnd[223:0], $random(seed)};
         tmp  = $random(seed);
         flip = tmp[31:8] % 230;                        // Bit hit in corrupt rows
         u    = rnd[229:0];
         tab[r].lane    = r[0];
         tab[r].ic      = tmp[1:0];
         tab[r].ec      = tmp[3:2];
         tab[r].user    = u;
         tab[r].corrupt = CORRUPT_ROWS[r];
         if (CORRUPT_ROWS[r]) u[flip] = ~u[flip];
         tab[r].exp_user = u;
      end
   endtask

   task automatic check_frame(input int lane, input sp3_rx_pkg::rx_frame_t f);
      int    r;
      string tag;
      if ((lane == 0 && exp_a.size() == 0) || (lane == 1 && exp_b.size() == 0)) begin
         report_error($sformatf("lane %0d gave a frame that is not in the table", lane));
      end else begin
         if (lane == 0) r = exp_a.pop_front();
         else           r = exp_b.pop_front();
         tag = $sformatf("row %0d lane %s", r, (lane == 0) ? "A" : "B");
         assert (f.ic == tab[r].ic) else report_value({tag, " ic"}, tab[r].ic, f.ic);
         assert (f.ec == tab[r].ec) else report_value({tag, " ec"}, tab[r].ec, f.ec);
         assert (f.user == tab[r].exp_user)
            else report_value({tag, " user"}, tab[r].exp_user, f.user);
         assert (f.fec_err == tab[r].corrupt)
            else report_value({tag, " fec_err"}, tab[r].corrupt, f.fec_err);
      end
   endtask

   // Zero user data marks filler frames
   always @(negedge MGT_RXCLK) begin
      if (check_on) begin
         if (frame_a_o.valid && frame_a_o.user != '0) check_frame(0, frame_a_o);
         if (frame_b_o.valid && frame_b_o.user != '0) check_frame(1, frame_b_o);
      end
   end

   // Send every row, check the frames, then the error counters
   task automatic run_table();
      int                      n_err [2];
      sp3_rx_pkg::frame_bits_t f;
      n_err[0] = 0;
      n_err[1] = 0;
      write_reg(sp3_rx_pkg::ADDR_ERRCNT_A, '0);
      write_reg(sp3_rx_pkg::ADDR_ERRCNT_B, '0);
      @(negedge MGT_RXCLK);
      for (int r = 0; r < TAB_ROWS; r++) begin
         f         = make_frame(2'b01, tab[r].ic, tab[r].ec, tab[r].user);
         f[249:20] = tab[r].exp_user;                   // Flip after parity
         push_frame(tab[r].lane, f, 0);
         if (tab[r].lane == 1'b0) exp_a.push_back(r);
         else                     exp_b.push_back(r);
         n_err[tab[r].lane] += tab[r].corrupt;
      end
      check_on = 1'b1;
      while (exp_a.size() != 0 || exp_b.size() != 0) @(negedge MGT_RXCLK);
      check_on = 1'b0;
      check_reg("ERRCNT_A", sp3_rx_pkg::ADDR_ERRCNT_A, sp3_rx_pkg::reg_data_t'(n_err[0]));
      check_reg("ERRCNT_B", sp3_rx_pkg::ADDR_ERRCNT_B, sp3_rx_pkg::reg_data_t'(n_err[1]));
      write_reg(sp3_rx_pkg::ADDR_ERRCNT_A, '0);
      write_reg(sp3_rx_pkg::ADDR_ERRCNT_B, '0);
      check_reg("ERRCNT_A cleared", sp3_rx_pkg::ADDR_ERRCNT_A, '0);
      check_reg("ERRCNT_B cleared", sp3_rx_pkg::ADDR_ERRCNT_B, '0);
   endtask

   task automatic wait_lock_both();
      @(negedge MGT_RXCLK);
      while (!(rdy_a_o && rdy_b_o)) @(negedge MGT_RXCLK);
   endtask

   ///////////////////////////////////////////////////////////////////
   // Test sequence
   initial begin
      rst_n_i     <= 1'b0;
      mgt_word_i  <= '0;
      cfg_we_i    <= 1'b0;
      cfg_addr_i  <= '0;
      cfg_wdata_i <= '0;
      seed        = 49077;
      cycle_cnt   = 0;
      lane_nxt    = 1'b0;
      invert      = 1'b0;
      check_on    = 1'b0;
      fill_cnt[0] = 0;
      fill_cnt[1] = 0;
      build_table();
      push_filler(0, 5);                                // Lane A starts 5 bits in
      push_filler(1, 19);
      repeat (8) @(posedge MGT_RXCLK);
      rst_n_i <= 1'b1;

      // Quiet state after reset
      @(negedge MGT_RXCLK);
      assert (!rdy_a_o) else report_value("rdy_a after reset", 0, rdy_a_o);
      assert (!rdy_b_o) else report_value("rdy_b after reset", 0, rdy_b_o);
      assert (!frame_a_o.valid) else report_value("valid A after reset", 0, frame_a_o.valid);
      assert (!frame_b_o.valid) else report_value("valid B after reset", 0, frame_b_o.valid);
      check_reg("CTRL after reset", sp3_rx_pkg::ADDR_CTRL, '0);
      check_reg("STATUS after reset", sp3_rx_pkg::ADDR_STATUS, '0);
      check_reg("ERRCNT_A after reset", sp3_rx_pkg::ADDR_ERRCNT_A, '0);
      check_reg("ERRCNT_B after reset", sp3_rx_pkg::ADDR_ERRCNT_B, '0);

      wait_lock_both();
      check_reg("STATUS after lock", sp3_rx_pkg::ADDR_STATUS, 16'd3);
      run_table();

      // Inverted link undone by CTRL polarity, then a lane reset pulse
      @(negedge MGT_RXCLK);
      invert = 1'b1;
      write_reg(sp3_rx_pkg::ADDR_CTRL, 16'h1);
      write_reg(sp3_rx_pkg::ADDR_CTRL, 16'h7);
      write_reg(sp3_rx_pkg::ADDR_CTRL, 16'h1);
      @(negedge MGT_RXCLK);
      assert (!rdy_a_o && !rdy_b_o) else report_error("lane reset pulse did not drop rdy");
      wait_lock_both();
      check_reg("CTRL with polarity", sp3_rx_pkg::ADDR_CTRL, 16'h1);
      run_table();

      // Lane B reset alone, lane A keeps its lock
      write_reg(sp3_rx_pkg::ADDR_CTRL, 16'h5);
      repeat (2) @(negedge MGT_RXCLK);
      assert (!rdy_b_o) else report_value("rdy_b in lane B reset", 0, rdy_b_o);
      assert (rdy_a_o) else report_value("rdy_a in lane B reset", 1, rdy_a_o);
      write_reg(sp3_rx_pkg::ADDR_CTRL, 16'h1);
      @(negedge MGT_RXCLK);
      while (!rdy_b_o) begin
         assert (rdy_a_o) else report_value("rdy_a while lane B relocks", 1, rdy_a_o);
         @(negedge MGT_RXCLK);
      end
      check_reg("STATUS after lane B relock", sp3_rx_pkg::ADDR_STATUS, 16'd3);

      $display("TB PASSED");
      $finish;
   end

endmodule

// ==== sp3_dual_rx.f ====
verilog/sp3_rx_pkg.sv
verilog/sp3_demux.sv
verilog/sp3_frame_aligner.sv
verilog/sp3_frame_decoder.sv
verilog/sp3_rx_regs.sv
verilog/sp3_dual_rx.sv
test/sp3_dual_rx_tb.sv
